/* hw/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_ADDI = 6'd5,
		OP_MUL  = 6'd6,
		OP_J    = 6'd7,
		OP_HALT = 6'd8
	} opcode_t;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [13:0] pc_t;
	typedef logic [12:0] bundle_addr_t;
	typedef logic [15:0] imm_t;

	// result latencies in cycles after issue
	localparam int LAT_ALU    = 1;
	localparam int LAT_MUL    = 3;
	localparam int LAT_MASK_W = 4;

	// instruction field positions
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 26;
	localparam int RD_MSB  = 25;
	localparam int RD_LSB  = 21;
	localparam int RS_MSB  = 20;
	localparam int RS_LSB  = 16;
	localparam int RT_MSB  = 15;
	localparam int RT_LSB  = 11;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

endpackage

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire                   i_stall,
	input  wire                   i_redirect,
	input  wire ooo_pkg::pc_t     i_target,
	input  wire                   i_halted,
	output ooo_pkg::bundle_addr_t o_imem_addr,
	output ooo_pkg::pc_t          o_fetch_pc,
	output logic                  o_slot0_en,
	output logic                  o_slot1_en
);
	import ooo_pkg::*;

	pc_t  pc_q;
	pc_t  fetch_pc_q;
	logic drop_q;
	logic stall_q;
	logic bundle_ok;

	assign o_imem_addr = pc_q[13:1];
	assign o_fetch_pc  = fetch_pc_q;

	// returning bundle is fresh unless it follows a redirect or repeats under stall
	assign bundle_ok  = !drop_q && !stall_q && !i_halted;
	// odd jump target starts in slot 1
	assign o_slot0_en = bundle_ok && !fetch_pc_q[0];
	assign o_slot1_en = bundle_ok;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc_q       <= '0;
			fetch_pc_q <= '0;
			drop_q     <= 1'b1;
			stall_q    <= 1'b0;
		end else begin
			fetch_pc_q <= pc_q;
			drop_q     <= i_redirect;
			stall_q    <= i_stall;
			if (i_halted) begin
				pc_q <= pc_q;
			end else if (i_redirect) begin
				pc_q <= i_target;
			end else if (!i_stall) begin
				pc_q <= {pc_q[13:1] + 13'd1, 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire ooo_pkg::word_t  i_instr0,
	input  wire ooo_pkg::word_t  i_instr1,
	input  wire                  i_en0,
	input  wire                  i_en1,
	output ooo_pkg::opcode_t     o_op0,
	output ooo_pkg::opcode_t     o_op1,
	output ooo_pkg::reg_addr_t   o_rd0,
	output ooo_pkg::reg_addr_t   o_rs0,
	output ooo_pkg::reg_addr_t   o_rt0,
	output ooo_pkg::reg_addr_t   o_rd1,
	output ooo_pkg::reg_addr_t   o_rs1,
	output ooo_pkg::reg_addr_t   o_rt1,
	output ooo_pkg::imm_t        o_imm0,
	output ooo_pkg::imm_t        o_imm1,
	output logic                 o_is_mul0,
	output logic                 o_is_mul1,
	output logic                 o_vld0,
	output logic                 o_vld1,
	output logic                 o_jump,
	output ooo_pkg::pc_t         o_target
);
	import ooo_pkg::*;

	logic live0, live1;
	logic jmp0, jmp1;

	// unused register fields read back as r0
	function automatic void dec_slot(input word_t instr, input logic en,
			output opcode_t op, output reg_addr_t rd, output reg_addr_t rs,
			output reg_addr_t rt, output imm_t imm, output logic is_mul,
			output logic live, output logic jmp);
		op = opcode_t'(instr[OPC_MSB:OPC_LSB]);
		if (op > OP_HALT)
			op = OP_NOP;
		rd = instr[RD_MSB:RD_LSB];
		rs = instr[RS_MSB:RS_LSB];
		rt = instr[RT_MSB:RT_LSB];
		imm = instr[IMM_MSB:IMM_LSB];
		if (op == OP_ADDI)
			rt = '0;
		if (op == OP_NOP || op == OP_J || op == OP_HALT) begin
			rd = '0;
			rs = '0;
			rt = '0;
		end
		is_mul = (op == OP_MUL);
		jmp = en && (op == OP_J);
		// nops and jumps never occupy the window
		live = en && (op != OP_NOP) && (op != OP_J);
	endfunction

	always_comb begin
		dec_slot(i_instr0, i_en0, o_op0, o_rd0, o_rs0, o_rt0, o_imm0, o_is_mul0, live0, jmp0);
		dec_slot(i_instr1, i_en1, o_op1, o_rd1, o_rs1, o_rt1, o_imm1, o_is_mul1, live1, jmp1);
	end

	// slot 1 is dead behind a taken slot 0 jump
	assign o_vld0   = live0;
	assign o_vld1   = live1 && !jmp0;
	assign o_jump   = jmp0 || jmp1;
	assign o_target = jmp0 ? o_imm0[13:0] : o_imm1[13:0];

endmodule

`default_nettype wire

/* hw/issue_window.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_window #(
	parameter int WIN_DEPTH = 3
) (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire ooo_pkg::opcode_t    i_op0,
	input  wire ooo_pkg::reg_addr_t  i_rd0,
	input  wire ooo_pkg::reg_addr_t  i_rs0,
	input  wire ooo_pkg::reg_addr_t  i_rt0,
	input  wire ooo_pkg::imm_t       i_imm0,
	input  wire                      i_is_mul0,
	input  wire                      i_vld0,
	input  wire ooo_pkg::opcode_t    i_op1,
	input  wire ooo_pkg::reg_addr_t  i_rd1,
	input  wire ooo_pkg::reg_addr_t  i_rs1,
	input  wire ooo_pkg::reg_addr_t  i_rt1,
	input  wire ooo_pkg::imm_t       i_imm1,
	input  wire                      i_is_mul1,
	input  wire                      i_vld1,
	input  wire [31:0]               i_busy_bits,
	input  wire [ooo_pkg::LAT_MASK_W-1:0] i_lat_busy,
	input  wire ooo_pkg::word_t      i_rs_val,
	input  wire ooo_pkg::word_t      i_rt_val,
	input  wire                      i_redirect,
	output logic                     o_stall,
	output ooo_pkg::reg_addr_t       o_rs,
	output ooo_pkg::reg_addr_t       o_rt,
	output logic                     o_issue,
	output ooo_pkg::opcode_t         o_issue_op,
	output ooo_pkg::reg_addr_t       o_issue_rd,
	output ooo_pkg::imm_t            o_issue_imm,
	output ooo_pkg::word_t           o_issue_a,
	output ooo_pkg::word_t           o_issue_b,
	output logic                     o_halted
);
	import ooo_pkg::*;

	// window entries, index 0 oldest
	logic      vld_q [WIN_DEPTH];
	opcode_t   op_q  [WIN_DEPTH];
	reg_addr_t rd_q  [WIN_DEPTH];
	reg_addr_t rs_q  [WIN_DEPTH];
	reg_addr_t rt_q  [WIN_DEPTH];
	imm_t      imm_q [WIN_DEPTH];
	logic      mul_q [WIN_DEPTH];

	logic      nxt_vld [WIN_DEPTH];
	opcode_t   nxt_op  [WIN_DEPTH];
	reg_addr_t nxt_rd  [WIN_DEPTH];
	reg_addr_t nxt_rs  [WIN_DEPTH];
	reg_addr_t nxt_rt  [WIN_DEPTH];
	imm_t      nxt_imm [WIN_DEPTH];
	logic      nxt_mul [WIN_DEPTH];

	// skid holds one decoded bundle
	logic      skid_vld_q;
	logic      sk_vld [2];
	opcode_t   sk_op  [2];
	reg_addr_t sk_rd  [2];
	reg_addr_t sk_rs  [2];
	reg_addr_t sk_rt  [2];
	imm_t      sk_imm [2];
	logic      sk_mul [2];

	logic      in_vld [2];
	opcode_t   in_op  [2];
	reg_addr_t in_rd  [2];
	reg_addr_t in_rs  [2];
	reg_addr_t in_rt  [2];
	imm_t      in_imm [2];
	logic      in_mul [2];

	logic elig [WIN_DEPTH];
	logic go;
	logic halt_go;
	int   sel;
	int   rem;
	logic halted_q;

	// decoder output, or the skid bundle when it is pending
	always_comb begin
		in_vld[0] = skid_vld_q ? sk_vld[0] : i_vld0;
		in_op[0]  = skid_vld_q ? sk_op[0]  : i_op0;
		in_rd[0]  = skid_vld_q ? sk_rd[0]  : i_rd0;
		in_rs[0]  = skid_vld_q ? sk_rs[0]  : i_rs0;
		in_rt[0]  = skid_vld_q ? sk_rt[0]  : i_rt0;
		in_imm[0] = skid_vld_q ? sk_imm[0] : i_imm0;
		in_mul[0] = skid_vld_q ? sk_mul[0] : i_is_mul0;
		in_vld[1] = skid_vld_q ? sk_vld[1] : i_vld1;
		in_op[1]  = skid_vld_q ? sk_op[1]  : i_op1;
		in_rd[1]  = skid_vld_q ? sk_rd[1]  : i_rd1;
		in_rs[1]  = skid_vld_q ? sk_rs[1]  : i_rs1;
		in_rt[1]  = skid_vld_q ? sk_rt[1]  : i_rt1;
		in_imm[1] = skid_vld_q ? sk_imm[1] : i_imm1;
		in_mul[1] = skid_vld_q ? sk_mul[1] : i_is_mul1;
	end

	always_comb begin
		for (int i = 0; i < WIN_DEPTH; i++) begin
			elig[i] = vld_q[i];
			if (op_q[i] == OP_HALT) begin
				// halt only drains from the head with nothing pending
				elig[i] = elig[i] && (i == 0) && (i_busy_bits == '0);
			end else begin
				if (i_busy_bits[rs_q[i]] || i_busy_bits[rt_q[i]] || i_busy_bits[rd_q[i]])
					elig[i] = 1'b0;
				if (i_lat_busy[mul_q[i] ? LAT_MUL : LAT_ALU])
					elig[i] = 1'b0;
				for (int j = 0; j < i; j++) begin
					if (vld_q[j]) begin
						if (op_q[j] == OP_HALT)
							elig[i] = 1'b0;
						// raw and waw against older writers
						if (rd_q[j] != '0 && (rd_q[j] == rs_q[i] || rd_q[j] == rt_q[i] ||
								rd_q[j] == rd_q[i]))
							elig[i] = 1'b0;
						// war against older readers
						if (rd_q[i] != '0 && (rs_q[j] == rd_q[i] || rt_q[j] == rd_q[i]))
							elig[i] = 1'b0;
					end
				end
			end
		end
	end

	// oldest eligible wins
	always_comb begin
		go = 1'b0;
		sel = 0;
		for (int i = WIN_DEPTH - 1; i >= 0; i--) begin
			if (elig[i] && !halted_q) begin
				go = 1'b1;
				sel = i;
			end
		end
	end

	assign halt_go     = go && (op_q[sel] == OP_HALT);
	assign o_issue     = go && (op_q[sel] != OP_HALT);
	assign o_issue_op  = op_q[sel];
	assign o_issue_rd  = rd_q[sel];
	assign o_issue_imm = imm_q[sel];
	assign o_rs        = rs_q[sel];
	assign o_rt        = rt_q[sel];
	assign o_issue_a   = i_rs_val;
	assign o_issue_b   = i_rt_val;
	assign o_halted    = halted_q;

	always_comb begin
		rem = 0;
		for (int i = 0; i < WIN_DEPTH; i++) begin
			if (vld_q[i] && !(go && sel == i))
				rem = rem + 1;
		end
	end

	assign o_stall = (rem >= WIN_DEPTH - 1);

	// compaction toward entry 0, then append the new bundle
	always_comb begin
		int k;
		k = 0;
		for (int i = 0; i < WIN_DEPTH; i++) begin
			nxt_vld[i] = 1'b0;
			nxt_op[i]  = op_q[i];
			nxt_rd[i]  = rd_q[i];
			nxt_rs[i]  = rs_q[i];
			nxt_rt[i]  = rt_q[i];
			nxt_imm[i] = imm_q[i];
			nxt_mul[i] = mul_q[i];
		end
		for (int i = 0; i < WIN_DEPTH; i++) begin
			if (vld_q[i] && !(go && sel == i)) begin
				nxt_vld[k] = 1'b1;
				nxt_op[k]  = op_q[i];
				nxt_rd[k]  = rd_q[i];
				nxt_rs[k]  = rs_q[i];
				nxt_rt[k]  = rt_q[i];
				nxt_imm[k] = imm_q[i];
				nxt_mul[k] = mul_q[i];
				k = k + 1;
			end
		end
		if (!o_stall && !halted_q) begin
			for (int s = 0; s < 2; s++) begin
				if (in_vld[s] && k < WIN_DEPTH) begin
					nxt_vld[k] = 1'b1;
					nxt_op[k]  = in_op[s];
					nxt_rd[k]  = in_rd[s];
					nxt_rs[k]  = in_rs[s];
					nxt_rt[k]  = in_rt[s];
					nxt_imm[k] = in_imm[s];
					nxt_mul[k] = in_mul[s];
					k = k + 1;
				end
			end
		end
		if (halt_go) begin
			for (int i = 0; i < WIN_DEPTH; i++)
				nxt_vld[i] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < WIN_DEPTH; i++)
				vld_q[i] <= 1'b0;
			skid_vld_q <= 1'b0;
			halted_q   <= 1'b0;
		end else begin
			for (int i = 0; i < WIN_DEPTH; i++)
				vld_q[i] <= nxt_vld[i];
			if (halt_go)
				halted_q <= 1'b1;
			if (!o_stall)
				skid_vld_q <= 1'b0;
			else if ((i_vld0 || i_vld1) && !halted_q)
				skid_vld_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < WIN_DEPTH; i++) begin
			op_q[i]  <= nxt_op[i];
			rd_q[i]  <= nxt_rd[i];
			rs_q[i]  <= nxt_rs[i];
			rt_q[i]  <= nxt_rt[i];
			imm_q[i] <= nxt_imm[i];
			mul_q[i] <= nxt_mul[i];
		end
		// catch the bundle that arrives in the first stalled cycle
		if (o_stall && !skid_vld_q) begin
			sk_vld[0] <= i_vld0;
			sk_op[0]  <= i_op0;
			sk_rd[0]  <= i_rd0;
			sk_rs[0]  <= i_rs0;
			sk_rt[0]  <= i_rt0;
			sk_imm[0] <= i_imm0;
			sk_mul[0] <= i_is_mul0;
			sk_vld[1] <= i_vld1;
			sk_op[1]  <= i_op1;
			sk_rd[1]  <= i_rd1;
			sk_rs[1]  <= i_rs1;
			sk_rt[1]  <= i_rt1;
			sk_imm[1] <= i_imm1;
			sk_mul[1] <= i_is_mul1;
		end
	end

	// an issued destination pends on the scoreboard from the next cycle
	a_issue_rd_pending: assert property (@(posedge clk) disable iff (!rstn)
		(o_issue && o_issue_rd != '0) |=> i_busy_bits[$past(o_issue_rd)]);

	// a redirect comes only from a fresh bundle, never while the skid is waiting
	a_no_redirect_on_skid: assert property (@(posedge clk) disable iff (!rstn)
		skid_vld_q |-> !i_redirect);

endmodule

`default_nettype wire

/* hw/scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire                      i_issue,
	input  wire ooo_pkg::reg_addr_t  i_issue_rd,
	input  wire                      i_wb_vld,
	input  wire ooo_pkg::reg_addr_t  i_wb_addr,
	output logic [31:0]              o_busy_bits
);
	logic [31:0] bits_q;
	logic [31:0] set_mask;
	logic [31:0] clr_mask;

	assign set_mask = i_issue ? (32'd1 << i_issue_rd) : '0;
	assign clr_mask = i_wb_vld ? (32'd1 << i_wb_addr) : '0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			bits_q <= '0;
		end else begin
			// r0 never pends
			bits_q <= ((bits_q & ~clr_mask) | set_mask) & ~32'd1;
		end
	end

	assign o_busy_bits = bits_q;

	a_wb_pending: assert property (@(posedge clk) disable iff (!rstn)
		(i_wb_vld && i_wb_addr != '0) |-> bits_q[i_wb_addr]);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire ooo_pkg::reg_addr_t  i_rs,
	input  wire ooo_pkg::reg_addr_t  i_rt,
	input  wire                      i_wb_vld,
	input  wire ooo_pkg::reg_addr_t  i_wb_addr,
	input  wire ooo_pkg::word_t      i_wb_data,
	output ooo_pkg::word_t           o_rs_val,
	output ooo_pkg::word_t           o_rt_val
);
	import ooo_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rstn && i_wb_vld && i_wb_addr != '0)
			regs[i_wb_addr] <= i_wb_data;
	end

	// r0 reads as zero
	assign o_rs_val = (i_rs == '0) ? '0 : regs[i_rs];
	assign o_rt_val = (i_rt == '0) ? '0 : regs[i_rt];

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire                      i_issue,
	input  wire ooo_pkg::opcode_t    i_op,
	input  wire ooo_pkg::reg_addr_t  i_rd,
	input  wire ooo_pkg::word_t      i_a,
	input  wire ooo_pkg::word_t      i_b,
	input  wire ooo_pkg::imm_t       i_imm,
	output logic [ooo_pkg::LAT_MASK_W-1:0] o_lat_busy,
	output logic                     o_wb_vld,
	output ooo_pkg::reg_addr_t       o_wb_addr,
	output ooo_pkg::word_t           o_wb_data
);
	import ooo_pkg::*;

	logic      is_mul;
	logic      alu_go;
	word_t     alu_res;
	logic      m1_vld_q, m2_vld_q;
	word_t     m1_a_q, m1_b_q;
	reg_addr_t m1_rd_q, m2_rd_q;
	word_t     m2_prod_q;

	assign is_mul = (i_op == OP_MUL);
	assign alu_go = i_issue && !is_mul;

	always_comb begin
		case (i_op)
			OP_ADD:  alu_res = i_a + i_b;
			OP_SUB:  alu_res = i_a - i_b;
			OP_AND:  alu_res = i_a & i_b;
			OP_OR:   alu_res = i_a | i_b;
			OP_ADDI: alu_res = i_a + {{16{i_imm[15]}}, i_imm};
			default: alu_res = '0;
		endcase
	end

	// bit n set: write port taken n cycles from now
	assign o_lat_busy = {1'b0, m1_vld_q, m2_vld_q, o_wb_vld};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			m1_vld_q <= 1'b0;
			m2_vld_q <= 1'b0;
			o_wb_vld <= 1'b0;
		end else begin
			m1_vld_q <= i_issue && is_mul;
			m2_vld_q <= m1_vld_q;
			o_wb_vld <= alu_go || m2_vld_q;
		end
	end

	always_ff @(posedge clk) begin
		m1_a_q    <= i_a;
		m1_b_q    <= i_b;
		m1_rd_q   <= i_rd;
		m2_prod_q <= m1_a_q * m1_b_q;
		m2_rd_q   <= m1_rd_q;
		if (m2_vld_q) begin
			o_wb_addr <= m2_rd_q;
			o_wb_data <= m2_prod_q;
		end else begin
			o_wb_addr <= i_rd;
			o_wb_data <= alu_res;
		end
	end

	a_one_writer: assert property (@(posedge clk) disable iff (!rstn)
		!(alu_go && m2_vld_q));

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
	parameter int WIN_DEPTH = 3
) (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire [63:0]               i_imem_data,
	output ooo_pkg::bundle_addr_t    o_imem_addr,
	output logic                     o_wb_vld,
	output ooo_pkg::reg_addr_t       o_wb_addr,
	output ooo_pkg::word_t           o_wb_data,
	output logic                     o_halted
);
	import ooo_pkg::*;

	pc_t       target;
	logic      slot0_en, slot1_en, stall, jump;
	opcode_t   op0, op1, issue_op;
	reg_addr_t rd0, rs0, rt0, rd1, rs1, rt1;
	reg_addr_t rs, rt, issue_rd;
	imm_t      imm0, imm1, issue_imm;
	logic      is_mul0, is_mul1, vld0, vld1;
	logic      issue;
	logic [31:0] busy_bits;
	logic [LAT_MASK_W-1:0] lat_busy;
	word_t     rs_val, rt_val, issue_a, issue_b;

	fetch_unit fetch_unit_inst (
		.clk(clk), .rstn(rstn), .i_stall(stall), .i_redirect(jump), .i_target(target),
		.i_halted(o_halted), .o_imem_addr(o_imem_addr), .o_fetch_pc(),
		.o_slot0_en(slot0_en), .o_slot1_en(slot1_en)
	);

	// slot 0 sits in the upper half of the bundle
	instr_decoder instr_decoder_inst (
		.i_instr0(i_imem_data[63:32]), .i_instr1(i_imem_data[31:0]),
		.i_en0(slot0_en), .i_en1(slot1_en),
		.o_op0(op0), .o_op1(op1), .o_rd0(rd0), .o_rs0(rs0), .o_rt0(rt0),
		.o_rd1(rd1), .o_rs1(rs1), .o_rt1(rt1), .o_imm0(imm0), .o_imm1(imm1),
		.o_is_mul0(is_mul0), .o_is_mul1(is_mul1), .o_vld0(vld0), .o_vld1(vld1),
		.o_jump(jump), .o_target(target)
	);

	issue_window #(.WIN_DEPTH(WIN_DEPTH)) issue_window_inst (
		.clk(clk), .rstn(rstn),
		.i_op0(op0), .i_rd0(rd0), .i_rs0(rs0), .i_rt0(rt0), .i_imm0(imm0),
		.i_is_mul0(is_mul0), .i_vld0(vld0),
		.i_op1(op1), .i_rd1(rd1), .i_rs1(rs1), .i_rt1(rt1), .i_imm1(imm1),
		.i_is_mul1(is_mul1), .i_vld1(vld1),
		.i_busy_bits(busy_bits), .i_lat_busy(lat_busy), .i_rs_val(rs_val),
		.i_rt_val(rt_val), .i_redirect(jump), .o_stall(stall), .o_rs(rs), .o_rt(rt),
		.o_issue(issue), .o_issue_op(issue_op), .o_issue_rd(issue_rd),
		.o_issue_imm(issue_imm), .o_issue_a(issue_a), .o_issue_b(issue_b),
		.o_halted(o_halted)
	);

	scoreboard scoreboard_inst (
		.clk(clk), .rstn(rstn), .i_issue(issue), .i_issue_rd(issue_rd),
		.i_wb_vld(o_wb_vld), .i_wb_addr(o_wb_addr), .o_busy_bits(busy_bits)
	);

	reg_file reg_file_inst (
		.clk(clk), .rstn(rstn), .i_rs(rs), .i_rt(rt), .i_wb_vld(o_wb_vld),
		.i_wb_addr(o_wb_addr), .i_wb_data(o_wb_data), .o_rs_val(rs_val), .o_rt_val(rt_val)
	);

	exec_unit exec_unit_inst (
		.clk(clk), .rstn(rstn), .i_issue(issue), .i_op(issue_op), .i_rd(issue_rd),
		.i_a(issue_a), .i_b(issue_b), .i_imm(issue_imm), .o_lat_busy(lat_busy),
		.o_wb_vld(o_wb_vld), .o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data)
	);

endmodule

`default_nettype wire

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// in-order model of prog[0 .. prog_len-1]
// fills exp_q with the values each register receives, oldest first
// returns the total number of register writes
function automatic int build_expected();
	word_t     regs [32];
	word_t     instr;
	opcode_t   op;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	imm_t      imm;
	word_t     res;
	int        pc;
	int        next_pc;
	int        count;
	logic      writes;
	logic      done;
	for (int r = 0; r < 32; r++) begin
		regs[r] = '0;
		exp_q[r].delete();
	end
	pc    = 0;
	count = 0;
	done  = 1'b0;
	while (!done && pc < prog_len) begin
		instr   = prog[pc];
		op      = opcode_t'(instr[OPC_MSB:OPC_LSB]);
		rd      = instr[RD_MSB:RD_LSB];
		rs      = instr[RS_MSB:RS_LSB];
		rt      = instr[RT_MSB:RT_LSB];
		imm     = instr[IMM_MSB:IMM_LSB];
		next_pc = pc + 1;
		writes  = 1'b0;
		res     = '0;
		case (op)
			OP_ADD: begin
				res    = regs[rs] + regs[rt];
				writes = 1'b1;
			end
			OP_SUB: begin
				res    = regs[rs] - regs[rt];
				writes = 1'b1;
			end
			OP_AND: begin
				res    = regs[rs] & regs[rt];
				writes = 1'b1;
			end
			OP_OR: begin
				res    = regs[rs] | regs[rt];
				writes = 1'b1;
			end
			OP_ADDI: begin
				res    = regs[rs] + {{16{imm[15]}}, imm};
				writes = 1'b1;
			end
			OP_MUL: begin
				res    = regs[rs] * regs[rt];
				writes = 1'b1;
			end
			// everything between the jump and its target is skipped
			OP_J: next_pc = int'(imm[13:0]);
			OP_HALT: done = 1'b1;
			default: writes = 1'b0;
		endcase
		// r0 stays zero and is never reported
		if (writes && rd != '0) begin
			regs[rd] = res;
			exp_q[rd].push_back(res);
			count = count + 1;
		end
		pc = next_pc;
	end
	return count;
endfunction

`endif

/* dv/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import ooo_pkg::*;

	localparam int PROG_LEN    = 120;
	localparam int IMEM_WORDS  = 256;
	// r1..r7 are written, r0..r7 are read
	localparam int NUM_REGS    = 8;
	localparam int CYCLE_LIMIT = 20 * PROG_LEN + 100;
	localparam int TAIL_CYCLES = 20;

	logic         clk;
	logic         rstn;
	logic [63:0]  imem_data;
	bundle_addr_t imem_addr;
	logic         wb_vld;
	reg_addr_t    wb_addr;
	word_t        wb_data;
	logic         halted;

	word_t        prog [IMEM_WORDS];
	int           prog_len;
	word_t        exp_q [32][$];
	int           exp_total;
	int           wb_count;
	int           cycle_cnt = 0;
	bundle_addr_t addr_prev;
	integer       seed;

	`include "tb_ref_model.svh"

	ooo_core #(.WIN_DEPTH(3)) ooo_core_inst (
		.clk(clk), .rstn(rstn), .i_imem_data(imem_data), .o_imem_addr(imem_addr),
		.o_wb_vld(wb_vld), .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			fail_now($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic word_t rtype_word(input opcode_t op, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		word_t w;
		w = '0;
		w[OPC_MSB:OPC_LSB] = op;
		w[RD_MSB:RD_LSB]   = rd;
		w[RS_MSB:RS_LSB]   = rs;
		w[RT_MSB:RT_LSB]   = rt;
		return w;
	endfunction

	function automatic word_t itype_word(input opcode_t op, input reg_addr_t rd,
			input reg_addr_t rs, input imm_t imm);
		word_t w;
		w = '0;
		w[OPC_MSB:OPC_LSB] = op;
		w[RD_MSB:RD_LSB]   = rd;
		w[RS_MSB:RS_LSB]   = rs;
		w[IMM_MSB:IMM_LSB] = imm;
		return w;
	endfunction

	// halts tagged with their own word index
	function automatic word_t halt_fill_word(input int idx);
		return {OP_HALT, 26'(idx)};
	endfunction

	function automatic logic [63:0] read_bundle(input bundle_addr_t addr);
		int idx;
		idx = int'(addr) * 2;
		if (idx + 1 < IMEM_WORDS)
			return {prog[idx], prog[idx + 1]};
		return {halt_fill_word(idx), halt_fill_word(idx + 1)};
	endfunction

	task automatic gen_program();
		int        p;
		int        kind;
		int        target;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		for (int i = 0; i < IMEM_WORDS; i++)
			prog[i] = halt_fill_word(i);
		// give every register a value before anything reads it
		for (int r = 1; r < NUM_REGS; r++)
			prog[r - 1] = itype_word(OP_ADDI, reg_addr_t'(r), '0, imm_t'($random(seed)));
		for (p = NUM_REGS - 1; p < PROG_LEN - 1; p++) begin
			kind = rand_below(16);
			rd   = reg_addr_t'(1 + rand_below(NUM_REGS - 1));
			rs   = reg_addr_t'(rand_below(NUM_REGS));
			rt   = reg_addr_t'(rand_below(NUM_REGS));
			if (kind < 3) begin
				prog[p] = rtype_word(OP_ADD, rd, rs, rt);
			end else if (kind < 5) begin
				prog[p] = rtype_word(OP_SUB, rd, rs, rt);
			end else if (kind < 7) begin
				prog[p] = rtype_word(OP_AND, rd, rs, rt);
			end else if (kind < 9) begin
				prog[p] = rtype_word(OP_OR, rd, rs, rt);
			end else if (kind < 12) begin
				prog[p] = itype_word(OP_ADDI, rd, rs, imm_t'($random(seed)));
			end else if (kind < 14) begin
				prog[p] = rtype_word(OP_MUL, rd, rs, rt);
			end else if (kind == 14) begin
				// forward jump, never past the final halt
				target = p + 2 + rand_below(5);
				if (target > PROG_LEN - 1)
					target = PROG_LEN - 1;
				prog[p] = itype_word(OP_J, '0, '0, imm_t'(target));
			end else begin
				prog[p] = itype_word(OP_NOP, '0, '0, '0);
			end
		end
		prog[PROG_LEN - 1] = itype_word(OP_HALT, '0, '0, '0);
		prog_len = PROG_LEN;
	endtask

	// memory answers one cycle after the address
	always @(negedge clk) begin
		imem_data <= read_bundle(addr_prev);
		addr_prev <= imem_addr;
	end

	always @(negedge clk) begin
		word_t expected;
		if (rstn && wb_vld) begin
			if (halted) begin
				fail_now("write-back seen after the core halted");
			end else if (wb_addr == '0) begin
				fail_now("write-back targets register 0");
			end else if (exp_q[wb_addr].size() == 0) begin
				fail_now($sformatf("unexpected extra write-back to r%0d", wb_addr));
			end else begin
				expected = exp_q[wb_addr].pop_front();
				check_value($sformatf("wb_order r%0d", wb_addr), expected, wb_data);
				wb_count = wb_count + 1;
			end
		end
	end

	always @(negedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			fail_now($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
	end

	initial begin
		seed      = 32'h03dd662a;
		rstn      = 1'b0;
		imem_data = '0;
		addr_prev = '0;
		wb_count  = 0;
		gen_program();
		exp_total = build_expected();
		repeat (4) @(negedge clk);
		check_value("reset_state wb_vld", 0, wb_vld);
		check_value("reset_state halted", 0, halted);
		rstn = 1'b1;
		@(negedge clk);
		check_value("reset_state wb_vld", 0, wb_vld);
		check_value("reset_state halted", 0, halted);
		while (!halted)
			@(negedge clk);
		// everything must have drained before halt took effect
		check_value("halt_drain write_count", exp_total, wb_count);
		for (int r = 0; r < 32; r++)
			check_value($sformatf("halt_drain r%0d pending", r), 0, exp_q[r].size());
		repeat (TAIL_CYCLES) begin
			@(negedge clk);
			check_value("halt_hold halted", 1, halted);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/ooo_pkg.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/issue_window.sv
hw/scoreboard.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/ooo_core.sv
dv/tb_top.sv
+incdir+include

/* Makefile */
TOP = tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
